// File: common/inbound_pkg.sv
`default_nettype none

package inbound_pkg;

    localparam int DATA_W = 32;

    typedef logic [DATA_W-1:0] tlp_word_t;

    // Fmt in bits 6:5, type in bits 4:0
    typedef enum logic [6:0] {
        FT_MRD32 = 7'b00_00000,
        FT_MWR32 = 7'b10_00000,
        FT_CPL   = 7'b00_01010,
        FT_CPLD  = 7'b10_01010
    } fmt_type_t;

    typedef enum logic [2:0] {
        CS_SC = 3'b000,
        CS_CA = 3'b100
    } cpl_status_t;

    // Bus 15:8, device 7:3, function 2:0
    typedef logic [15:0] req_id_t;

    typedef logic [7:0] tag_t;

    typedef logic [3:0] be_t;

    typedef logic [1:0] axi_resp_t;

endpackage

`default_nettype wire

// File: decode/bar_translate.sv
`timescale 1ns/1ps
`default_nettype none

module bar_translate #(
    parameter int              ADDR      = 32,
    parameter logic [ADDR-1:0] BAR0_MASK = '1,
    parameter logic [ADDR-1:0] BAR0_BASE = '0,
    parameter logic [ADDR-1:0] BAR1_MASK = '1,
    parameter logic [ADDR-1:0] BAR1_BASE = '0
) (
    input  wire  [6:0]      bar,
    input  wire  [31:0]     tlp_addr,
    output logic [ADDR-1:0] axi_addr,
    output logic            hit
);

    logic [ADDR-1:0] addr_ext;

    assign addr_ext = ADDR'(tlp_addr);

    // Only BAR0 and BAR1 are mapped onto AXI
    always_comb begin
        hit = 1'b1;
        case (bar)
            7'b000_0001: axi_addr = BAR0_BASE | (addr_ext & BAR0_MASK);
            7'b000_0010: axi_addr = BAR1_BASE | (addr_ext & BAR1_MASK);
            default: begin
                hit      = 1'b0;
                axi_addr = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: decode/tlp_decode.sv
`timescale 1ns/1ps
`default_nettype none

module tlp_decode #(
    parameter int              ADDR      = 32,
    parameter logic [ADDR-1:0] BAR0_MASK = '1,
    parameter logic [ADDR-1:0] BAR0_BASE = '0,
    parameter logic [ADDR-1:0] BAR1_MASK = '1,
    parameter logic [ADDR-1:0] BAR1_BASE = '0
) (
    input  wire                         axi_clk,
    input  wire                         rst_n,
    input  wire                         rx_valid,
    input  wire inbound_pkg::tlp_word_t rx_data,
    input  wire                         rx_last,
    input  wire                         rx_err,
    input  wire  [6:0]                  rx_bar,
    output logic                        rx_ready,
    output logic                        cmd_valid,
    output logic                        cmd_write,
    output logic [ADDR-1:0]             cmd_addr,
    output inbound_pkg::tlp_word_t      cmd_data,
    output inbound_pkg::be_t            cmd_be,
    output inbound_pkg::req_id_t        cmd_req_id,
    output inbound_pkg::tag_t           cmd_tag,
    output logic [6:0]                  cmd_lower_addr,
    input  wire                         exec_done,
    output logic                        err_valid,
    output logic                        err_unsupported,
    input  wire                         err_ready
);

    typedef enum logic [2:0] {S_GAP, S_RX, S_CMD, S_WAIT, S_ERR} state_t;

    state_t                 state;
    logic [2:0]             wcnt;
    logic                   err_q;
    inbound_pkg::fmt_type_t fmt_q;
    logic [9:0]             len_q;
    logic [6:0]             bar_q;
    logic [31:0]            addr_q;
    logic                   hit;
    logic [1:0]             be_off;
    logic                   rx_hs;
    logic                   is_rd;
    logic                   is_wr;
    logic                   supported;

    bar_translate #(
        .ADDR      (ADDR),
        .BAR0_MASK (BAR0_MASK),
        .BAR0_BASE (BAR0_BASE),
        .BAR1_MASK (BAR1_MASK),
        .BAR1_BASE (BAR1_BASE)
    ) u_bar_translate (
        .bar      (bar_q),
        .tlp_addr (addr_q),
        .axi_addr (cmd_addr),
        .hit      (hit)
    );

    assign rx_hs = rx_valid && rx_ready;

    // wcnt holds the index of the word now on rx_data
    assign is_rd     = (fmt_q == inbound_pkg::FT_MRD32) && (wcnt == 3'd2);
    assign is_wr     = (fmt_q == inbound_pkg::FT_MWR32) && (wcnt == 3'd3);
    assign supported = (is_rd || is_wr) && (len_q == 10'd1) && hit;

    always_ff @(posedge axi_clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_GAP;
            wcnt  <= '0;
            err_q <= 1'b0;
        end else begin
            case (state)
                S_GAP: state <= S_RX;
                S_RX: begin
                    if (rx_hs && rx_last) begin
                        wcnt  <= '0;
                        err_q <= 1'b0;
                        if (err_q || rx_err) begin
                            state <= S_GAP;
                        end else if (supported) begin
                            state <= S_CMD;
                        end else begin
                            state <= S_ERR;
                        end
                    end else if (rx_hs) begin
                        err_q <= err_q || rx_err;
                        // Saturate so long TLPs never alias a short one
                        if (wcnt != 3'd4) begin
                            wcnt <= wcnt + 3'd1;
                        end
                    end
                end
                S_CMD:  state <= S_WAIT;
                S_WAIT: if (exec_done) state <= S_RX;
                S_ERR:  if (err_ready) state <= S_RX;
                default: state <= S_GAP;
            endcase
        end
    end

    always_ff @(posedge axi_clk) begin
        if (rx_hs) begin
            case (wcnt)
                3'd0: begin
                    fmt_q <= inbound_pkg::fmt_type_t'(rx_data[30:24]);
                    len_q <= rx_data[9:0];
                    bar_q <= rx_bar;
                end
                3'd1: begin
                    cmd_req_id <= rx_data[31:16];
                    cmd_tag    <= rx_data[15:8];
                    cmd_be     <= rx_data[3:0];
                end
                3'd2: addr_q <= {rx_data[31:2], 2'b00};
                3'd3: cmd_data <= rx_data;
                default: ;
            endcase
        end
    end

    // Offset of the first enabled byte
    always_comb begin
        casez (cmd_be)
            4'b???1: be_off = 2'd0;
            4'b??10: be_off = 2'd1;
            4'b?100: be_off = 2'd2;
            4'b1000: be_off = 2'd3;
            default: be_off = 2'd0;
        endcase
    end

    assign cmd_lower_addr  = {addr_q[6:2], be_off};
    assign cmd_write       = (fmt_q == inbound_pkg::FT_MWR32);
    assign rx_ready        = (state == S_RX);
    assign cmd_valid       = (state == S_CMD);
    assign err_valid       = (state == S_ERR);
    assign err_unsupported = (state == S_ERR);

endmodule

`default_nettype wire

// File: filelist.f
common/inbound_pkg.sv
decode/bar_translate.sv
decode/tlp_decode.sv
src/axi_execute.sv
src/cpl_encode.sv
src/pcie_inbound.sv
testbench/tb_clock.sv
testbench/tb_pcie_inbound.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module tb_pcie_inbound -o sim_tb
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "All tests passed!"; then
    exit 0
fi
exit 1

// File: src/axi_execute.sv
`timescale 1ns/1ps
`default_nettype none

module axi_execute #(
    parameter int ADDR = 32
) (
    input  wire                                 axi_clk,
    input  wire                                 rst_n,
    input  wire                                 cmd_valid,
    input  wire                                 cmd_write,
    input  wire  [ADDR-1:0]                     cmd_addr,
    input  wire inbound_pkg::tlp_word_t         cmd_data,
    input  wire inbound_pkg::be_t               cmd_be,
    input  wire inbound_pkg::req_id_t           cmd_req_id,
    input  wire inbound_pkg::tag_t              cmd_tag,
    input  wire  [6:0]                          cmd_lower_addr,
    output logic                                exec_done,
    output logic                                aw_valid,
    input  wire                                 aw_ready,
    output logic [ADDR-1:0]                     aw_addr,
    output logic                                w_valid,
    input  wire                                 w_ready,
    output logic [inbound_pkg::DATA_W-1:0]      w_data,
    output inbound_pkg::be_t                    w_strb,
    output logic                                b_ready,
    input  wire                                 b_valid,
    input  wire inbound_pkg::axi_resp_t         b_resp,
    output logic                                ar_valid,
    input  wire                                 ar_ready,
    output logic [ADDR-1:0]                     ar_addr,
    output logic                                r_ready,
    input  wire                                 r_valid,
    input  wire  [inbound_pkg::DATA_W-1:0]      r_data,
    input  wire inbound_pkg::axi_resp_t         r_resp,
    output logic                                cpl_start,
    output inbound_pkg::tlp_word_t              cpl_data,
    output inbound_pkg::axi_resp_t              cpl_resp,
    output inbound_pkg::be_t                    cpl_be,
    output inbound_pkg::req_id_t                cpl_req_id,
    output inbound_pkg::tag_t                   cpl_tag,
    output logic [6:0]                          cpl_lower_addr,
    input  wire                                 cpl_done
);

    typedef enum logic [2:0] {E_IDLE, E_WR, E_B, E_AR, E_R, E_CPL} state_t;

    state_t state;
    logic   b_done;

    // Write status is not forwarded, so b_resp only completes the handshake
    assign exec_done = b_done || cpl_done;

    always_ff @(posedge axi_clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= E_IDLE;
            aw_valid  <= 1'b0;
            w_valid   <= 1'b0;
            b_ready   <= 1'b0;
            ar_valid  <= 1'b0;
            r_ready   <= 1'b0;
            cpl_start <= 1'b0;
            b_done    <= 1'b0;
        end else begin
            cpl_start <= 1'b0;
            b_done    <= 1'b0;
            case (state)
                E_IDLE: begin
                    if (cmd_valid && cmd_write) begin
                        aw_valid <= 1'b1;
                        w_valid  <= 1'b1;
                        state    <= E_WR;
                    end else if (cmd_valid) begin
                        ar_valid <= 1'b1;
                        state    <= E_AR;
                    end
                end
                E_WR: begin
                    // aw and w complete independently
                    if (aw_ready) aw_valid <= 1'b0;
                    if (w_ready) w_valid <= 1'b0;
                    if ((!aw_valid || aw_ready) && (!w_valid || w_ready)) begin
                        b_ready <= 1'b1;
                        state   <= E_B;
                    end
                end
                E_B: begin
                    if (b_valid) begin
                        b_ready <= 1'b0;
                        b_done  <= 1'b1;
                        state   <= E_IDLE;
                    end
                end
                E_AR: begin
                    if (ar_ready) begin
                        ar_valid <= 1'b0;
                        r_ready  <= 1'b1;
                        state    <= E_R;
                    end
                end
                E_R: begin
                    if (r_valid) begin
                        r_ready   <= 1'b0;
                        cpl_start <= 1'b1;
                        state     <= E_CPL;
                    end
                end
                E_CPL: if (cpl_done) state <= E_IDLE;
                default: state <= E_IDLE;
            endcase
        end
    end

    always_ff @(posedge axi_clk) begin
        if (state == E_IDLE && cmd_valid) begin
            aw_addr        <= cmd_addr;
            ar_addr        <= cmd_addr;
            w_data         <= cmd_data;
            w_strb         <= cmd_be;
            cpl_be         <= cmd_be;
            cpl_req_id     <= cmd_req_id;
            cpl_tag        <= cmd_tag;
            cpl_lower_addr <= cmd_lower_addr;
        end
        if (r_valid && r_ready) begin
            cpl_data <= r_data;
            cpl_resp <= r_resp;
        end
    end

endmodule

`default_nettype wire

// File: src/cpl_encode.sv
`timescale 1ns/1ps
`default_nettype none

module cpl_encode (
    input  wire                         axi_clk,
    input  wire                         rst_n,
    input  wire                         cpl_start,
    input  wire inbound_pkg::tlp_word_t cpl_data,
    input  wire inbound_pkg::axi_resp_t cpl_resp,
    input  wire inbound_pkg::be_t       cpl_be,
    input  wire inbound_pkg::req_id_t   cpl_req_id,
    input  wire inbound_pkg::tag_t      cpl_tag,
    input  wire  [6:0]                  cpl_lower_addr,
    input  wire  [7:0]                  bus_number,
    input  wire  [4:0]                  dev_number,
    input  wire  [2:0]                  func_number,
    output logic                        cpl_done,
    output logic                        tx_valid,
    output inbound_pkg::tlp_word_t      tx_data,
    output logic                        tx_last,
    input  wire                         tx_ready
);

    logic [1:0]                 widx;
    logic                       ok;
    logic [1:0]                 be_hi;
    logic [11:0]                byte_cnt;
    inbound_pkg::fmt_type_t     fmt;
    inbound_pkg::cpl_status_t   status;

    // OKAY is the only good response
    assign ok     = (cpl_resp == 2'b00);
    assign fmt    = ok ? inbound_pkg::FT_CPLD : inbound_pkg::FT_CPL;
    assign status = ok ? inbound_pkg::CS_SC : inbound_pkg::CS_CA;

    always_comb begin
        casez (cpl_be)
            4'b1???: be_hi = 2'd3;
            4'b01??: be_hi = 2'd2;
            4'b001?: be_hi = 2'd1;
            default: be_hi = 2'd0;
        endcase
    end

    // Low end comes from the lower address offset; zero BE gives one byte
    assign byte_cnt = {10'd0, be_hi - cpl_lower_addr[1:0]} + 12'd1;

    always_comb begin
        case (widx)
            2'd0: tx_data = {1'b0, fmt, 14'd0, ok ? 10'd1 : 10'd0};
            2'd1: tx_data = {bus_number, dev_number, func_number, status, 1'b0, byte_cnt};
            2'd2: tx_data = {cpl_req_id, cpl_tag, 1'b0, cpl_lower_addr};
            default: tx_data = cpl_data;
        endcase
    end

    // No data word on an error completion
    assign tx_last = ok ? (widx == 2'd3) : (widx == 2'd2);

    always_ff @(posedge axi_clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_valid <= 1'b0;
            widx     <= '0;
            cpl_done <= 1'b0;
        end else begin
            cpl_done <= 1'b0;
            if (cpl_start) begin
                tx_valid <= 1'b1;
                widx     <= '0;
            end else if (tx_valid && tx_ready && tx_last) begin
                tx_valid <= 1'b0;
                cpl_done <= 1'b1;
            end else if (tx_valid && tx_ready) begin
                widx <= widx + 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/pcie_inbound.sv
`timescale 1ns/1ps
`default_nettype none

module pcie_inbound #(
    parameter int              ADDR      = 32,
    parameter logic [ADDR-1:0] BAR0_MASK = '1,
    parameter logic [ADDR-1:0] BAR0_BASE = '0,
    parameter logic [ADDR-1:0] BAR1_MASK = '1,
    parameter logic [ADDR-1:0] BAR1_BASE = '0
) (
    input  wire                             axi_clk,
    input  wire                             rst_n,
    input  wire                             rx_valid,
    input  wire inbound_pkg::tlp_word_t     rx_data,
    input  wire                             rx_last,
    input  wire                             rx_err,
    input  wire  [6:0]                      rx_bar,
    output logic                            rx_ready,
    output logic                            aw_valid,
    input  wire                             aw_ready,
    output logic [ADDR-1:0]                 aw_addr,
    output logic                            w_valid,
    input  wire                             w_ready,
    output logic [inbound_pkg::DATA_W-1:0]  w_data,
    output inbound_pkg::be_t                w_strb,
    output logic                            b_ready,
    input  wire                             b_valid,
    input  wire inbound_pkg::axi_resp_t     b_resp,
    output logic                            ar_valid,
    input  wire                             ar_ready,
    output logic [ADDR-1:0]                 ar_addr,
    output logic                            r_ready,
    input  wire                             r_valid,
    input  wire  [inbound_pkg::DATA_W-1:0]  r_data,
    input  wire inbound_pkg::axi_resp_t     r_resp,
    input  wire  [7:0]                      bus_number,
    input  wire  [4:0]                      dev_number,
    input  wire  [2:0]                      func_number,
    output logic                            tx_valid,
    output inbound_pkg::tlp_word_t          tx_data,
    output logic                            tx_last,
    input  wire                             tx_ready,
    output logic                            err_valid,
    output logic                            err_unsupported,
    input  wire                             err_ready
);

    logic                       cmd_valid;
    logic                       cmd_write;
    logic [ADDR-1:0]            cmd_addr;
    inbound_pkg::tlp_word_t     cmd_data;
    inbound_pkg::be_t           cmd_be;
    inbound_pkg::req_id_t       cmd_req_id;
    inbound_pkg::tag_t          cmd_tag;
    logic [6:0]                 cmd_lower_addr;
    logic                       exec_done;
    logic                       cpl_start;
    inbound_pkg::tlp_word_t     cpl_data;
    inbound_pkg::axi_resp_t     cpl_resp;
    inbound_pkg::be_t           cpl_be;
    inbound_pkg::req_id_t       cpl_req_id;
    inbound_pkg::tag_t          cpl_tag;
    logic [6:0]                 cpl_lower_addr;
    logic                       cpl_done;

    tlp_decode #(
        .ADDR      (ADDR),
        .BAR0_MASK (BAR0_MASK),
        .BAR0_BASE (BAR0_BASE),
        .BAR1_MASK (BAR1_MASK),
        .BAR1_BASE (BAR1_BASE)
    ) u_tlp_decode (.*);

    axi_execute #(
        .ADDR (ADDR)
    ) u_axi_execute (.*);

    cpl_encode u_cpl_encode (.*);

endmodule

`default_nettype wire

// File: testbench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int HALF_PERIOD  = 4,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Release just after an edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: testbench/tb_pcie_inbound.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pcie_inbound;

    localparam logic [31:0] B0_MASK = 32'h0000_ffff;
    localparam logic [31:0] B0_BASE = 32'h4000_0000;
    localparam logic [31:0] B1_MASK = 32'h0000_0fff;
    localparam logic [31:0] B1_BASE = 32'h8001_0000;

    logic        clk, rst_n;
    logic        rx_valid, rx_last, rx_err, rx_ready;
    logic [31:0] rx_data;
    logic [6:0]  rx_bar;
    logic        aw_valid, aw_ready, w_valid, w_ready, b_ready, b_valid;
    logic [31:0] aw_addr, w_data, ar_addr, r_data, tx_data;
    logic [3:0]  w_strb;
    logic [1:0]  b_resp, r_resp;
    logic        ar_valid, ar_ready, r_ready, r_valid;
    logic [7:0]  bus_number;
    logic [4:0]  dev_number;
    logic [2:0]  func_number;
    logic        tx_valid, tx_last, tx_ready;
    logic        err_valid, err_unsupported, err_ready;

    int          seed = 82;
    logic        stall = 1'b0;
    logic        resp_err = 1'b0;
    logic [31:0] tlp_buf [0:4];

    logic [31:0] exp_aw[$];
    logic [35:0] exp_w[$];
    logic [31:0] exp_ar[$];
    logic [31:0] exp_tx[$];
    int          exp_err = 0;

    // Responder and stall tracking
    logic        aw_seen, w_seen, b_pend, r_pend;
    logic [31:0] r_addr_q;
    logic        tx_hold, tx_hold_last, aw_hold, ar_hold;
    logic [31:0] tx_hold_data, aw_hold_addr, ar_hold_addr;

    tb_clock u_tb_clock (.clk(clk), .rst_n(rst_n));

    pcie_inbound #(
        .ADDR      (32),
        .BAR0_MASK (B0_MASK),
        .BAR0_BASE (B0_BASE),
        .BAR1_MASK (B1_MASK),
        .BAR1_BASE (B1_BASE)
    ) u_pcie_inbound (
        .axi_clk(clk), .rst_n(rst_n),
        .rx_valid(rx_valid), .rx_data(rx_data), .rx_last(rx_last), .rx_err(rx_err),
        .rx_bar(rx_bar), .rx_ready(rx_ready),
        .aw_valid(aw_valid), .aw_ready(aw_ready), .aw_addr(aw_addr),
        .w_valid(w_valid), .w_ready(w_ready), .w_data(w_data), .w_strb(w_strb),
        .b_ready(b_ready), .b_valid(b_valid), .b_resp(b_resp),
        .ar_valid(ar_valid), .ar_ready(ar_ready), .ar_addr(ar_addr),
        .r_ready(r_ready), .r_valid(r_valid), .r_data(r_data), .r_resp(r_resp),
        .bus_number(bus_number), .dev_number(dev_number), .func_number(func_number),
        .tx_valid(tx_valid), .tx_data(tx_data), .tx_last(tx_last), .tx_ready(tx_ready),
        .err_valid(err_valid), .err_unsupported(err_unsupported), .err_ready(err_ready)
    );

    task automatic check_failed(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic timeout_fail(input string msg);
        $display("Timeout: %s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    // Read data pattern covers every address bit
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return {addr[15:0], ~addr[31:16]} ^ 32'h5a5a_1234;
    endfunction

    function automatic logic [31:0] translate(input logic [6:0] bar, input logic [31:0] addr);
        if (bar == 7'b000_0001) return B0_BASE | (addr & B0_MASK);
        return B1_BASE | (addr & B1_MASK);
    endfunction

    function automatic int low_bit(input logic [3:0] be);
        int lo;
        lo = 0;
        for (int i = 3; i >= 0; i--) if (be[i]) lo = i;
        return lo;
    endfunction

    function automatic logic [11:0] byte_count(input logic [3:0] be);
        int hi;
        hi = 0;
        if (be == 4'd0) return 12'd1;
        for (int i = 0; i < 4; i++) if (be[i]) hi = i;
        return 12'(hi - low_bit(be) + 1);
    endfunction

    task automatic send_tlp(input int n, input logic [6:0] bar, input int err_at);
        int t;
        for (int i = 0; i < n; i++) begin
            rx_valid = 1'b1;
            rx_data  = tlp_buf[i];
            rx_last  = (i == n - 1);
            rx_err   = (i == err_at);
            rx_bar   = bar;
            t = 0;
            while (!rx_ready) begin
                @(posedge clk);
                #1;
                t++;
                if (t > 300) timeout_fail("receive stream never became ready");
            end
            @(posedge clk);
            #1;
        end
        rx_valid = 1'b0;
        rx_last  = 1'b0;
        rx_err   = 1'b0;
    endtask

    task automatic wait_idle();
        int t;
        t = 0;
        while (!(rx_ready && exp_aw.size() == 0 && exp_w.size() == 0 && exp_ar.size() == 0
                 && exp_tx.size() == 0 && exp_err == 0)) begin
            @(posedge clk);
            #1;
            t++;
            if (t > 500) timeout_fail("request did not complete");
        end
    endtask

    task automatic do_write(input logic [6:0] bar, input logic [31:0] addr,
                            input logic [3:0] be, input logic [31:0] data);
        tlp_buf[0] = {1'b0, 7'b10_00000, 14'd0, 10'd1};
        tlp_buf[1] = {16'h0100, 8'h21, 4'h0, be};
        tlp_buf[2] = addr;
        tlp_buf[3] = data;
        exp_aw.push_back(translate(bar, addr));
        exp_w.push_back({be, data});
        send_tlp(4, bar, -1);
        wait_idle();
    endtask

    task automatic do_read(input logic [6:0] bar, input logic [15:0] rid, input logic [7:0] tag,
                           input logic [31:0] addr, input logic [3:0] be, input logic bad);
        logic [31:0] axi;
        logic [6:0]  lower;
        axi   = translate(bar, addr);
        lower = {addr[6:2], 2'(low_bit(be))};
        resp_err = bad;
        tlp_buf[0] = {1'b0, 7'b00_00000, 14'd0, 10'd1};
        tlp_buf[1] = {rid, tag, 4'h0, be};
        tlp_buf[2] = addr;
        exp_ar.push_back(axi);
        if (bad) begin
            exp_tx.push_back({1'b0, 7'b00_01010, 14'd0, 10'd0});
            exp_tx.push_back({bus_number, dev_number, func_number, 3'b100, 1'b0, byte_count(be)});
        end else begin
            exp_tx.push_back({1'b0, 7'b10_01010, 14'd0, 10'd1});
            exp_tx.push_back({bus_number, dev_number, func_number, 3'b000, 1'b0, byte_count(be)});
        end
        exp_tx.push_back({rid, tag, 1'b0, lower});
        if (!bad) exp_tx.push_back(mem_word(axi));
        send_tlp(3, bar, -1);
        wait_idle();
    endtask

    // Sampling at the clock edge, responder bookkeeping and checks
    always @(posedge clk) begin
        if (!rst_n) begin
            assert (!aw_valid && !w_valid && !ar_valid && !tx_valid && !err_valid)
                else check_failed("valid output high during reset");
            aw_seen = 1'b0;
            w_seen  = 1'b0;
            b_pend  = 1'b0;
            r_pend  = 1'b0;
            tx_hold = 1'b0;
            aw_hold = 1'b0;
            ar_hold = 1'b0;
        end else begin
            assert (!aw_valid || exp_aw.size() > 0) else check_failed("unexpected aw_valid");
            assert (!w_valid || exp_w.size() > 0) else check_failed("unexpected w_valid");
            assert (!ar_valid || exp_ar.size() > 0) else check_failed("unexpected ar_valid");
            assert (!tx_valid || exp_tx.size() > 0) else check_failed("unexpected tx word");
            assert (!err_valid || exp_err > 0) else check_failed("unexpected err_valid");
            if (tx_hold)
                assert (tx_valid && tx_data == tx_hold_data && tx_last == tx_hold_last)
                    else check_failed("tx word changed while stalled");
            if (aw_hold)
                assert (aw_valid && aw_addr == aw_hold_addr)
                    else check_failed("aw changed while stalled");
            if (ar_hold)
                assert (ar_valid && ar_addr == ar_hold_addr)
                    else check_failed("ar changed while stalled");
            if (aw_valid && aw_ready) begin
                assert (aw_addr == exp_aw[0]) else check_failed("wrong aw_addr");
                void'(exp_aw.pop_front());
                aw_seen = 1'b1;
            end
            if (w_valid && w_ready) begin
                assert ({w_strb, w_data} == exp_w[0]) else check_failed("wrong w_data or w_strb");
                void'(exp_w.pop_front());
                w_seen = 1'b1;
            end
            if (aw_seen && w_seen) begin
                aw_seen = 1'b0;
                w_seen  = 1'b0;
                b_pend  = 1'b1;
            end
            if (b_valid && b_ready) b_pend = 1'b0;
            if (ar_valid && ar_ready) begin
                assert (ar_addr == exp_ar[0]) else check_failed("wrong ar_addr");
                void'(exp_ar.pop_front());
                r_pend   = 1'b1;
                r_addr_q = ar_addr;
            end
            if (r_valid && r_ready) r_pend = 1'b0;
            if (tx_valid && tx_ready) begin
                assert (tx_data == exp_tx[0] && tx_last == (exp_tx.size() == 1))
                    else check_failed("wrong completion word");
                void'(exp_tx.pop_front());
            end
            if (err_valid && err_ready) begin
                assert (err_unsupported) else check_failed("err_unsupported low");
                exp_err--;
            end
            tx_hold      = tx_valid && !tx_ready;
            tx_hold_data = tx_data;
            tx_hold_last = tx_last;
            aw_hold      = aw_valid && !aw_ready;
            aw_hold_addr = aw_addr;
            ar_hold      = ar_valid && !ar_ready;
            ar_hold_addr = ar_addr;
        end
    end

    // AXI responder and sink ready signals
    initial begin
        logic [31:0] rnd;
        aw_ready  = 1'b0;
        w_ready   = 1'b0;
        ar_ready  = 1'b0;
        b_valid   = 1'b0;
        b_resp    = 2'b00;
        r_valid   = 1'b0;
        r_data    = '0;
        r_resp    = 2'b00;
        tx_ready  = 1'b0;
        err_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            rnd       = $random(seed);
            aw_ready  = !stall || (rnd[1:0] != 2'd0);
            w_ready   = !stall || (rnd[3:2] != 2'd0);
            ar_ready  = !stall || (rnd[5:4] != 2'd0);
            tx_ready  = !stall || (rnd[7:6] != 2'd0);
            err_ready = !stall || rnd[8];
            b_valid   = b_pend;
            r_valid   = r_pend;
            r_data    = mem_word(r_addr_q);
            r_resp    = resp_err ? 2'b10 : 2'b00;
        end
    end

    initial begin
        logic [31:0] rnd;
        logic [6:0]  bar;
        int          t;
        rx_valid    = 1'b0;
        rx_data     = '0;
        rx_last     = 1'b0;
        rx_err      = 1'b0;
        rx_bar      = '0;
        bus_number  = 8'h3c;
        dev_number  = 5'h05;
        func_number = 3'h2;
        t = 0;
        while (!rst_n) begin
            @(posedge clk);
            t++;
            if (t > 20) timeout_fail("reset never released");
        end
        @(posedge clk);
        #1;

        do_write(7'b000_0001, 32'h1234_5678, 4'b0110, 32'hdead_beef);
        do_read(7'b000_0010, 16'h0a18, 8'h12, 32'h0000_0058, 4'b1100, 1'b0);
        do_read(7'b000_0010, 16'h0a18, 8'h13, 32'h0000_0104, 4'b0011, 1'b1);

        // Two-DW write
        tlp_buf[0] = {1'b0, 7'b10_00000, 14'd0, 10'd2};
        tlp_buf[1] = 32'h0100_2a0f;
        tlp_buf[2] = 32'h0000_0040;
        tlp_buf[3] = 32'h1111_1111;
        tlp_buf[4] = 32'h2222_2222;
        exp_err = 1;
        send_tlp(5, 7'b000_0001, -1);
        wait_idle();
        // I/O read
        tlp_buf[0] = {1'b0, 7'b00_00010, 14'd0, 10'd1};
        exp_err = 1;
        send_tlp(3, 7'b000_0001, -1);
        wait_idle();
        // BAR2 hit
        tlp_buf[0] = {1'b0, 7'b00_00000, 14'd0, 10'd1};
        exp_err = 1;
        send_tlp(3, 7'b000_0100, -1);
        wait_idle();
        // Poisoned by rx_err, dropped without a trace
        tlp_buf[0] = {1'b0, 7'b10_00000, 14'd0, 10'd1};
        send_tlp(4, 7'b000_0001, 1);
        wait_idle();

        stall = 1'b1;
        for (int n = 0; n < 24; n++) begin
            rnd = $random(seed);
            bar = rnd[2] ? 7'b000_0010 : 7'b000_0001;
            if (rnd[1:0] < 2'd2)
                do_write(bar, $random(seed) & 32'hffff_fffc, rnd[7:4], $random(seed));
            else
                do_read(bar, rnd[31:16], rnd[15:8], $random(seed) & 32'hffff_fffc,
                        rnd[7:4], rnd[1:0] == 2'd3);
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire
